/* source/bus_defs.svh */
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// bus widths
`define BUS_ADDR_W      32
`define BUS_DATA_W      32
`define BUS_AXI_DATA_W  64

// mtime words, served locally and never sent to the bus
`define BUS_RTC_ADDR    32'ha000_0048
`define BUS_RTC_ADDR_UP (`BUS_RTC_ADDR + 32'd4)

`endif

/* source/bus_pkg.sv */
package bus_pkg;

  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_RD_ADDR  = 3'd1,
    ST_RD_DATA  = 3'd2,
    ST_WR_ADDR  = 3'd3,
    ST_WR_RESP  = 3'd4,
    ST_TIMER_RD = 3'd5
  } arb_state_t;

  // axi size encoding
  typedef enum logic [2:0] {
    SIZE_BYTE = 3'd0,
    SIZE_HALF = 3'd1,
    SIZE_WORD = 3'd2
  } axi_size_t;

  // requester strobe to transfer size, unknown patterns fall back to byte
  function automatic axi_size_t strb_to_size(input logic [7:0] strb);
    axi_size_t size;
    case (strb)
      8'h03:   size = SIZE_HALF;
      8'h0f:   size = SIZE_WORD;
      default: size = SIZE_BYTE;
    endcase
    return size;
  endfunction

endpackage

/* source/bus_arbiter_fsm.sv */
`timescale 1ns/1ps

module bus_arbiter_fsm (
  input  logic clk,
  input  logic rst,
  input  logic ifu_arvalid_i,
  input  logic lsu_arvalid_i,
  input  logic lsu_wvalid_i,
  input  logic timer_hit_i,
  input  logic arready_i,
  input  logic awready_i,
  input  logic wready_i,
  input  logic rvalid_i,
  input  logic bvalid_i,
  output logic grant_lsu_o,
  output logic timer_sel_o,
  output logic arvalid_o,
  output logic awvalid_o,
  output logic wvalid_o,
  output logic ifu_done_o,
  output logic lsu_rdone_o,
  output logic lsu_wdone_o
);
  import bus_pkg::*;

  arb_state_t state;
  arb_state_t state_nxt;
  logic       grant_lsu_nxt;
  logic       aw_done;
  logic       w_done;
  logic       aw_fire;
  logic       w_fire;
  logic       wr_addr_end;

  assign arvalid_o   = (state == ST_RD_ADDR);
  assign awvalid_o   = (state == ST_WR_ADDR) && !aw_done;
  assign wvalid_o    = (state == ST_WR_ADDR) && !w_done;
  assign timer_sel_o = (state == ST_TIMER_RD);

  assign aw_fire     = awvalid_o && awready_i;
  assign w_fire      = wvalid_o && wready_i;
  assign wr_addr_end = (aw_done || aw_fire) && (w_done || w_fire); // aw and w in any order

  assign ifu_done_o  = (state == ST_RD_DATA) && rvalid_i && !grant_lsu_o;
  assign lsu_rdone_o = ((state == ST_RD_DATA) && rvalid_i && grant_lsu_o) || timer_sel_o;
  assign lsu_wdone_o = (state == ST_WR_RESP) && bvalid_i;

  always_comb
  begin
    state_nxt     = state;
    grant_lsu_nxt = grant_lsu_o;
    case (state)
      ST_IDLE:
      begin
        // store first, then load, then fetch
        if (lsu_wvalid_i)
        begin
          state_nxt     = ST_WR_ADDR;
          grant_lsu_nxt = 1'b1;
        end
        else if (lsu_arvalid_i)
        begin
          state_nxt     = timer_hit_i ? ST_TIMER_RD : ST_RD_ADDR;
          grant_lsu_nxt = 1'b1;
        end
        else if (ifu_arvalid_i)
        begin
          state_nxt     = ST_RD_ADDR;
          grant_lsu_nxt = 1'b0;
        end
      end
      ST_RD_ADDR:  if (arready_i) state_nxt = ST_RD_DATA;
      ST_RD_DATA:  if (rvalid_i) state_nxt = ST_IDLE;
      ST_WR_ADDR:  if (wr_addr_end) state_nxt = ST_WR_RESP;
      ST_WR_RESP:  if (bvalid_i) state_nxt = ST_IDLE;
      ST_TIMER_RD: state_nxt = ST_IDLE; // answered locally in one cycle
      default:     state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= ST_IDLE;
      grant_lsu_o <= 1'b0;
      aw_done     <= 1'b0;
      w_done      <= 1'b0;
    end
    else
    begin
      state       <= state_nxt;
      grant_lsu_o <= grant_lsu_nxt;
      if (wr_addr_end)
      begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end
      else
      begin
        if (aw_fire)
          aw_done <= 1'b1;
        if (w_fire)
          w_done <= 1'b1;
      end
    end
  end

  a_ar_aw_excl: assert property (@(posedge clk) disable iff (rst)
    !(arvalid_o && awvalid_o));

  // ar must not be withdrawn before the slave takes it
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    (arvalid_o && !arready_i) |=> arvalid_o);

endmodule

/* source/clint_timer.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module clint_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`BUS_ADDR_W-1:0] addr_i,
  output logic [`BUS_DATA_W-1:0] rdata_o
);

  logic [63:0] mtime;

  // free running, no compare
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime <= 64'd0;
    else
      mtime <= mtime + 64'd1;
  end

  always_comb
  begin
    case (addr_i)
      `BUS_RTC_ADDR:    rdata_o = mtime[31:0];
      `BUS_RTC_ADDR_UP: rdata_o = mtime[63:32];
      default:          rdata_o = '0;
    endcase
  end

endmodule

/* source/read_lane_steer.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module read_lane_steer (
  input  logic                       clk,
  input  logic                       grant_lsu_i,
  input  logic [`BUS_ADDR_W-1:0]     ifu_araddr_i,
  input  logic [`BUS_ADDR_W-1:0]     lsu_araddr_i,
  input  logic [7:0]                 lsu_rstrb_i,
  input  logic [`BUS_AXI_DATA_W-1:0] axi_rdata_i,
  input  logic [1:0]                 rresp_i,
  input  logic                       rvalid_i,
  input  logic [`BUS_DATA_W-1:0]     timer_rdata_i,
  input  logic                       timer_sel_i,
  output logic [`BUS_ADDR_W-1:0]     araddr_o,
  output bus_pkg::axi_size_t         arsize_o,
  output logic                       timer_hit_o,
  output logic [`BUS_DATA_W-1:0]     rdata_o
);
  import bus_pkg::*;

  logic [`BUS_DATA_W-1:0] lane_data;

  assign araddr_o = grant_lsu_i ? lsu_araddr_i : ifu_araddr_i;
  assign arsize_o = grant_lsu_i ? strb_to_size(lsu_rstrb_i) : SIZE_WORD; // fetch is a word

  assign timer_hit_o = (lsu_araddr_i == `BUS_RTC_ADDR) || (lsu_araddr_i == `BUS_RTC_ADDR_UP);

  // bit 2 picks the upper half
  assign lane_data = araddr_o[2] ? axi_rdata_i[63:32] : axi_rdata_i[31:0];
  assign rdata_o   = timer_sel_i ? timer_rdata_i : lane_data;

  a_rresp_okay: assert property (@(posedge clk)
    rvalid_i |-> (rresp_i == 2'b00));

endmodule

/* source/write_lane_align.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module write_lane_align (
  input  logic                       clk,
  input  logic [`BUS_ADDR_W-1:0]     awaddr_i,
  input  logic [`BUS_DATA_W-1:0]     wdata_i,
  input  logic [7:0]                 wstrb_i,
  input  logic                       bvalid_i,
  input  logic [1:0]                 bresp_i,
  output bus_pkg::axi_size_t         awsize_o,
  output logic [`BUS_AXI_DATA_W-1:0] axi_wdata_o,
  output logic [7:0]                 axi_wstrb_o
);
  import bus_pkg::*;

  logic [`BUS_DATA_W-1:0] wdata_sh;
  logic [3:0]             wstrb_sh;

  assign awsize_o = strb_to_size(wstrb_i);

  // byte offset within the word
  assign wdata_sh = wdata_i << {awaddr_i[1:0], 3'b000};
  assign wstrb_sh = wstrb_i[3:0] << awaddr_i[1:0];

  assign axi_wdata_o = {wdata_sh, wdata_sh}; // same data on both halves, strobes decide
  assign axi_wstrb_o = awaddr_i[2] ? {wstrb_sh, 4'b0000} : {4'b0000, wstrb_sh};

  a_bresp_okay: assert property (@(posedge clk)
    bvalid_i |-> (bresp_i == 2'b00));

endmodule

/* source/mem_bus_top.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module mem_bus_top (
  input  logic                       clk,
  input  logic                       rst,
  // fetch
  input  logic [`BUS_ADDR_W-1:0]     ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  output logic [`BUS_DATA_W-1:0]     ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  // load
  input  logic [`BUS_ADDR_W-1:0]     lsu_araddr_i,
  input  logic                       lsu_arvalid_i,
  input  logic [7:0]                 lsu_rstrb_i,
  output logic [`BUS_DATA_W-1:0]     lsu_rdata_o,
  output logic                       lsu_rvalid_o,
  // store
  input  logic [`BUS_ADDR_W-1:0]     lsu_awaddr_i,
  input  logic [`BUS_DATA_W-1:0]     lsu_wdata_i,
  input  logic [7:0]                 lsu_wstrb_i,
  input  logic                       lsu_wvalid_i,
  output logic                       lsu_wdone_o,
  // axi read
  output logic [`BUS_ADDR_W-1:0]     araddr_o,
  output bus_pkg::axi_size_t         arsize_o,
  output logic                       arvalid_o,
  input  logic                       arready_i,
  input  logic [`BUS_AXI_DATA_W-1:0] rdata_i,
  input  logic [1:0]                 rresp_i,
  input  logic                       rvalid_i,
  // axi write
  output logic [`BUS_ADDR_W-1:0]     awaddr_o,
  output bus_pkg::axi_size_t         awsize_o,
  output logic                       awvalid_o,
  input  logic                       awready_i,
  output logic [`BUS_AXI_DATA_W-1:0] wdata_o,
  output logic [7:0]                 wstrb_o,
  output logic                       wlast_o,
  output logic                       wvalid_o,
  input  logic                       wready_i,
  input  logic [1:0]                 bresp_i,
  input  logic                       bvalid_i
);

  logic                   grant_lsu;
  logic                   timer_sel;
  logic                   timer_hit;
  logic [`BUS_DATA_W-1:0] timer_rdata;
  logic [`BUS_DATA_W-1:0] steer_rdata;

  bus_arbiter_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .timer_hit_i   (timer_hit),
    .arready_i     (arready_i),
    .awready_i     (awready_i),
    .wready_i      (wready_i),
    .rvalid_i      (rvalid_i),
    .bvalid_i      (bvalid_i),
    .grant_lsu_o   (grant_lsu),
    .timer_sel_o   (timer_sel),
    .arvalid_o     (arvalid_o),
    .awvalid_o     (awvalid_o),
    .wvalid_o      (wvalid_o),
    .ifu_done_o    (ifu_rvalid_o),
    .lsu_rdone_o   (lsu_rvalid_o),
    .lsu_wdone_o   (lsu_wdone_o)
  );

  clint_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (lsu_araddr_i),
    .rdata_o (timer_rdata)
  );

  read_lane_steer u_rd_steer (
    .clk           (clk),
    .grant_lsu_i   (grant_lsu),
    .ifu_araddr_i  (ifu_araddr_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .axi_rdata_i   (rdata_i),
    .rresp_i       (rresp_i),
    .rvalid_i      (rvalid_i),
    .timer_rdata_i (timer_rdata),
    .timer_sel_i   (timer_sel),
    .araddr_o      (araddr_o),
    .arsize_o      (arsize_o),
    .timer_hit_o   (timer_hit),
    .rdata_o       (steer_rdata)
  );

  write_lane_align u_wr_align (
    .clk         (clk),
    .awaddr_i    (lsu_awaddr_i),
    .wdata_i     (lsu_wdata_i),
    .wstrb_i     (lsu_wstrb_i),
    .bvalid_i    (bvalid_i),
    .bresp_i     (bresp_i),
    .awsize_o    (awsize_o),
    .axi_wdata_o (wdata_o),
    .axi_wstrb_o (wstrb_o)
  );

  assign awaddr_o = lsu_awaddr_i;
  assign wlast_o  = wvalid_o; // single beat only

  // each requester only sees data with its own done
  assign ifu_rdata_o = ifu_rvalid_o ? steer_rdata : '0;
  assign lsu_rdata_o = lsu_rvalid_o ? steer_rdata : '0;

endmodule

/* bench/mem_bus_tb.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module mem_bus_tb;
  import bus_pkg::*;

  localparam logic [31:0] RAM_BASE = 32'h8000_0000;
  localparam int          TIMEOUT  = 64;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] ifu_araddr_i = '0;
  logic        ifu_arvalid_i = 1'b0;
  logic [31:0] ifu_rdata_o;
  logic        ifu_rvalid_o;
  logic [31:0] lsu_araddr_i = '0;
  logic        lsu_arvalid_i = 1'b0;
  logic [7:0]  lsu_rstrb_i = '0;
  logic [31:0] lsu_rdata_o;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_awaddr_i = '0;
  logic [31:0] lsu_wdata_i = '0;
  logic [7:0]  lsu_wstrb_i = '0;
  logic        lsu_wvalid_i = 1'b0;
  logic        lsu_wdone_o;
  logic [31:0] araddr_o;
  axi_size_t   arsize_o;
  logic        arvalid_o;
  logic        arready_i = 1'b0;
  logic [63:0] rdata_i = '0;
  logic [1:0]  rresp_i = 2'b00;
  logic        rvalid_i = 1'b0;
  logic [31:0] awaddr_o;
  axi_size_t   awsize_o;
  logic        awvalid_o;
  logic        awready_i = 1'b0;
  logic [63:0] wdata_o;
  logic [7:0]  wstrb_o;
  logic        wlast_o;
  logic        wvalid_o;
  logic        wready_i = 1'b0;
  logic [1:0]  bresp_i = 2'b00;
  logic        bvalid_i = 1'b0;

  logic [31:0] lfsr = 32'he61e904c;
  logic [63:0] mem [0:15];     // slave side storage
  logic [63:0] ref_mem [0:15]; // what the core should see
  logic [63:0] mtime_model = '0;
  int          errors = 0;
  int          checks = 0;
  int          ifu_pulses = 0;
  int          lsu_pulses = 0;
  int          wr_pulses = 0;
  int          ar_count = 0;
  int          ar_wait = 0;
  int          aw_wait = 0;
  int          w_wait = 0;
  logic        aw_got = 1'b0;
  logic        w_got = 1'b0;
  logic [31:0] aw_addr_q = '0;
  logic [63:0] w_data_q = '0;
  logic [7:0]  w_strb_q = '0;
  logic [31:0] exp_araddr = '0;
  axi_size_t   exp_arsize = SIZE_WORD;
  logic [31:0] exp_awaddr = '0;
  axi_size_t   exp_awsize = SIZE_BYTE;
  logic [63:0] exp_wdata = '0;
  logic [7:0]  exp_wstrb = '0;

  mem_bus_top dut0 (.*);

  always #2 clk = ~clk;

  // zero in the first cycle after release
  always @(posedge clk)
  begin
    if (rst)
      mtime_model <= '0;
    else
      mtime_model <= mtime_model + 64'd1;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb)
        lfsr = lfsr ^ 32'h8020_0003;
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  function automatic logic [63:0] fill_word(input int i);
    logic [31:0] a;
    a = RAM_BASE + 32'(8 * i);
    return {(a + 32'd4) ^ 32'h5a5a_a5a5, a ^ 32'h5a5a_a5a5};
  endfunction

  function automatic logic [31:0] ref_half(input logic [31:0] addr);
    return addr[2] ? ref_mem[addr[6:3]][63:32] : ref_mem[addr[6:3]][31:0];
  endfunction

  function automatic axi_size_t size_of_strb(input logic [7:0] strb);
    if (strb == 8'h03)
      return SIZE_HALF;
    else if (strb == 8'h0f)
      return SIZE_WORD;
    return SIZE_BYTE;
  endfunction

  function automatic logic [7:0] pick_strb(input logic [31:0] sel);
    case (sel)
      32'd0:   return 8'h01;
      32'd1:   return 8'h03;
      default: return 8'h0f;
    endcase
  endfunction

  function automatic logic done_of(input int which);
    case (which)
      0:       return ifu_rvalid_o;
      1:       return lsu_rvalid_o;
      default: return lsu_wdone_o;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
    end
  endtask

  // axi slave with random ready delays and R or B one cycle after the last handshake
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < 16; i++)
        mem[i] = fill_word(i);
      arready_i <= 1'b0;
      awready_i <= 1'b0;
      wready_i  <= 1'b0;
      rvalid_i  <= 1'b0;
      bvalid_i  <= 1'b0;
      aw_got = 1'b0;
      w_got  = 1'b0;
    end
    else
    begin
      arready_i <= 1'b0;
      awready_i <= 1'b0;
      wready_i  <= 1'b0;
      rvalid_i  <= 1'b0;
      bvalid_i  <= 1'b0;
      if (arvalid_o && arready_i)
      begin
        ar_count++;
        check_val("araddr_o", 64'(araddr_o), 64'(exp_araddr));
        check_val("arsize_o", 64'(arsize_o), 64'(exp_arsize));
        rdata_i  <= mem[araddr_o[6:3]];
        rvalid_i <= 1'b1;
        ar_wait = int'(rnd(2));
      end
      else if (arvalid_o)
      begin
        if (ar_wait == 0)
          arready_i <= 1'b1;
        else
          ar_wait--;
      end
      if (awvalid_o && awready_i)
      begin
        check_val("awaddr_o", 64'(awaddr_o), 64'(exp_awaddr));
        check_val("awsize_o", 64'(awsize_o), 64'(exp_awsize));
        aw_addr_q = awaddr_o;
        aw_got    = 1'b1;
        aw_wait   = int'(rnd(2));
      end
      else if (awvalid_o)
      begin
        if (aw_wait == 0)
          awready_i <= 1'b1;
        else
          aw_wait--;
      end
      if (wvalid_o && wready_i)
      begin
        check_val("wdata_o", wdata_o, exp_wdata);
        check_val("wstrb_o", 64'(wstrb_o), 64'(exp_wstrb));
        check_val("wlast_o", 64'(wlast_o), 64'd1);
        w_data_q = wdata_o;
        w_strb_q = wstrb_o;
        w_got    = 1'b1;
        w_wait   = int'(rnd(2));
      end
      else if (wvalid_o)
      begin
        if (w_wait == 0)
          wready_i <= 1'b1;
        else
          w_wait--;
      end
      if (aw_got && w_got)
      begin
        for (int b = 0; b < 8; b++)
          if (w_strb_q[b])
            mem[aw_addr_q[6:3]][8*b +: 8] = w_data_q[8*b +: 8];
        aw_got = 1'b0;
        w_got  = 1'b0;
        bvalid_i <= 1'b1;
      end
    end
  end

  // counts the cycle that ends at this edge
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (ifu_rvalid_o)
        ifu_pulses++;
      if (lsu_rvalid_o)
        lsu_pulses++;
      if (lsu_wdone_o)
        wr_pulses++;
      if (arvalid_o && awvalid_o)
      begin
        errors++;
        $display("arvalid_o and awvalid_o are high in the same cycle at %0t", $time);
      end
    end
  end

  task automatic wait_done(input int which, output int cyc);
    logic seen;
    seen = 1'b0;
    cyc  = 0;
    while (!seen && cyc < TIMEOUT)
    begin
      @(negedge clk);
      cyc++;
      seen = done_of(which);
    end
    if (!seen)
    begin
      errors++;
      $display("timeout: requester %0d got no done pulse in %0d cycles", which, TIMEOUT);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Simulation FAILED");
      $finish;
    end
  endtask

  task automatic check_quiet();
    check_val("arvalid_o", 64'(arvalid_o), 64'd0);
    check_val("awvalid_o", 64'(awvalid_o), 64'd0);
    check_val("wvalid_o", 64'(wvalid_o), 64'd0);
    check_val("ifu_rvalid_o", 64'(ifu_rvalid_o), 64'd0);
    check_val("lsu_rvalid_o", 64'(lsu_rvalid_o), 64'd0);
    check_val("lsu_wdone_o", 64'(lsu_wdone_o), 64'd0);
  endtask

  task automatic do_fetch(input logic [31:0] addr);
    int cyc;
    int pulses;
    pulses     = ifu_pulses;
    exp_araddr = addr;
    exp_arsize = SIZE_WORD;
    @(posedge clk);
    ifu_araddr_i  <= addr;
    ifu_arvalid_i <= 1'b1;
    wait_done(0, cyc);
    check_val("ifu_rdata_o", 64'(ifu_rdata_o), 64'(ref_half(addr)));
    @(posedge clk);
    ifu_arvalid_i <= 1'b0;
    repeat (2) @(negedge clk);
    check_val("ifu_rvalid_o pulses", 64'(ifu_pulses - pulses), 64'd1);
  endtask

  task automatic do_load(input logic [31:0] addr, input logic [7:0] strb);
    int          cyc;
    int          pulses;
    int          beats;
    logic        timer;
    logic [31:0] exp_word;
    timer      = (addr == `BUS_RTC_ADDR) || (addr == `BUS_RTC_ADDR_UP);
    pulses     = lsu_pulses;
    beats      = ar_count;
    exp_araddr = addr;
    exp_arsize = size_of_strb(strb);
    @(posedge clk);
    lsu_araddr_i  <= addr;
    lsu_rstrb_i   <= strb;
    lsu_arvalid_i <= 1'b1;
    wait_done(1, cyc);
    if (timer)
    begin
      exp_word = (addr == `BUS_RTC_ADDR) ? mtime_model[31:0] : mtime_model[63:32];
      check_val("lsu_rvalid_o delay", 64'(cyc), 64'd2); // idle sample then answer
    end
    else
      exp_word = ref_half(addr);
    check_val("lsu_rdata_o", 64'(lsu_rdata_o), 64'(exp_word));
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
    repeat (2) @(negedge clk);
    check_val("lsu_rvalid_o pulses", 64'(lsu_pulses - pulses), 64'd1);
    if (timer)
      check_val("arvalid_o handshakes", 64'(ar_count - beats), 64'd0);
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [7:0] strb,
                          input logic [31:0] data);
    int          cyc;
    int          pulses;
    int          lane;
    logic [31:0] shifted;
    pulses     = wr_pulses;
    shifted    = data << (8 * addr[1:0]);
    exp_awaddr = addr;
    exp_awsize = size_of_strb(strb);
    exp_wdata  = {shifted, shifted};
    exp_wstrb  = '0;
    for (int b = 0; b < 4; b++)
    begin
      if (strb[b])
      begin
        lane = int'(addr[2:0]) + b; // byte lane in the 64-bit word
        exp_wstrb[lane] = 1'b1;
        ref_mem[addr[6:3]][8*lane +: 8] = data[8*b +: 8];
      end
    end
    @(posedge clk);
    lsu_awaddr_i <= addr;
    lsu_wdata_i  <= data;
    lsu_wstrb_i  <= strb;
    lsu_wvalid_i <= 1'b1;
    wait_done(2, cyc);
    @(posedge clk);
    lsu_wvalid_i <= 1'b0;
    repeat (2) @(negedge clk);
    check_val("lsu_wdone_o pulses", 64'(wr_pulses - pulses), 64'd1);
  endtask

  // the load must win the port when both are raised together
  task automatic fetch_behind_load(input logic [31:0] faddr, input logic [31:0] laddr);
    int cyc;
    int ifu_before;
    int lsu_before;
    ifu_before = ifu_pulses;
    lsu_before = lsu_pulses;
    exp_araddr = laddr;
    exp_arsize = SIZE_WORD;
    @(posedge clk);
    ifu_araddr_i  <= faddr;
    ifu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= laddr;
    lsu_rstrb_i   <= 8'h0f;
    lsu_arvalid_i <= 1'b1;
    wait_done(1, cyc);
    check_val("lsu_rdata_o", 64'(lsu_rdata_o), 64'(ref_half(laddr)));
    exp_araddr = faddr;
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
    wait_done(0, cyc);
    check_val("ifu_rdata_o", 64'(ifu_rdata_o), 64'(ref_half(faddr)));
    @(posedge clk);
    ifu_arvalid_i <= 1'b0;
    repeat (2) @(negedge clk);
    check_val("ifu_rvalid_o pulses", 64'(ifu_pulses - ifu_before), 64'd1);
    check_val("lsu_rvalid_o pulses", 64'(lsu_pulses - lsu_before), 64'd1);
  endtask

  initial
  begin
    logic [31:0] addr;
    logic [7:0]  strb;
    int          op;
    for (int i = 0; i < 16; i++)
      ref_mem[i] = fill_word(i);
    @(posedge clk);
    @(negedge clk);
    check_quiet();
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_quiet();
    do_load(`BUS_RTC_ADDR, 8'h0f);
    do_load(`BUS_RTC_ADDR_UP, 8'h0f);
    fetch_behind_load(RAM_BASE + 32'h10, RAM_BASE + 32'h2c);
    for (int n = 0; n < 200; n++)
    begin
      op   = int'(rnd(2));
      strb = pick_strb(rnd(2));
      addr = RAM_BASE + rnd(7);
      if (strb == 8'h03)
        addr[0] = 1'b0;
      else if (strb == 8'h0f)
        addr[1:0] = 2'b00;
      case (op)
        0: do_fetch({addr[31:2], 2'b00});
        1: do_load(addr, strb);
        2:
        begin
          do_store(addr, strb, rnd(32));
          do_load(addr, strb);
        end
        default: do_load(rnd(1) ? `BUS_RTC_ADDR_UP : `BUS_RTC_ADDR, 8'h0f);
      endcase
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* mem_bus_top.f */
+incdir+source
source/bus_pkg.sv
source/bus_arbiter_fsm.sv
source/clint_timer.sv
source/read_lane_steer.sv
source/write_lane_align.sv
source/mem_bus_top.sv
bench/mem_bus_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mem_bus_tb
FILELIST  = mem_bus_top.f

OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
